/* Makefile */
TOP := tb_riscv_core
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f sources.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TEST OK$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module riscv_core

clean:
	rm -rf obj_dir $(LOG)

/* rtl/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  riscv_isa_pkg::alu_op_e op,
    input  riscv_isa_pkg::xlen_t   a,
    input  riscv_isa_pkg::xlen_t   b,
    output riscv_isa_pkg::xlen_t   result
);
    import riscv_isa_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt; // Sign fill
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

    // Decode only ever issues the ten defined codes
    always_comb begin
        if (!$isunknown(op)) begin
            op_legal: assert (op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
                                         ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND});
        end
    end

endmodule

`default_nettype wire

/* rtl/core_cfg_pkg.sv */
`default_nettype none

package core_cfg_pkg;

    localparam riscv_isa_pkg::addr_t    RESET_PC   = 32'h0000_0000;
    localparam int                      NUM_REGS   = 32;
    localparam riscv_isa_pkg::reg_idx_t TAP_REG    = 5'd10; // a0
    localparam riscv_isa_pkg::xlen_t    INSTR_STEP = 32'd4;

endpackage

`default_nettype wire

/* rtl/execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      flush,
    input  riscv_isa_pkg::addr_t      ex_pc,
    input  riscv_isa_pkg::reg_idx_t   ex_rs1,
    input  riscv_isa_pkg::reg_idx_t   ex_rs2,
    input  riscv_isa_pkg::reg_idx_t   ex_rd,
    input  riscv_isa_pkg::xlen_t      ex_data_a,
    input  riscv_isa_pkg::xlen_t      ex_data_b,
    input  riscv_isa_pkg::xlen_t      ex_imm,
    input  riscv_isa_pkg::alu_op_e    ex_alu_op,
    input  logic                      ex_use_imm,
    input  riscv_isa_pkg::branch_op_e ex_branch_op,
    input  logic                      ex_reg_write,
    output riscv_isa_pkg::branch_op_e mem_branch_op,
    output riscv_isa_pkg::xlen_t      mem_alu_result,
    output riscv_isa_pkg::addr_t      mem_branch_target,
    output logic                      wb_write_en,
    output riscv_isa_pkg::reg_idx_t   wb_rd,
    output riscv_isa_pkg::xlen_t      wb_data
);
    import riscv_isa_pkg::*;
    import core_cfg_pkg::*;

    reg_idx_t mem_rd;
    logic     mem_reg_write;
    xlen_t    op_a;
    xlen_t    op_b;
    xlen_t    alu_result;

    // Newest producer wins, x0 never forwarded
    function automatic xlen_t forward(reg_idx_t idx, xlen_t reg_value);
        if (mem_reg_write && mem_rd != '0 && mem_rd == idx) begin
            return mem_alu_result;
        end
        if (wb_write_en && wb_rd != '0 && wb_rd == idx) begin
            return wb_data;
        end
        return reg_value; // Already bypassed at register read
    endfunction

    // --------------------
    // Operand select
    // --------------------
    always_comb begin
        if (ex_branch_op == BR_JUMP) begin
            op_a = ex_pc; // Return address pc + 4
            op_b = INSTR_STEP;
        end else begin
            op_a = forward(ex_rs1, ex_data_a);
            op_b = ex_use_imm ? ex_imm : forward(ex_rs2, ex_data_b);
        end
    end

    alu u_alu (
        .op     (ex_alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result)
    );

    // --------------------
    // EX/MEM and MEM/WB
    // --------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_branch_op <= BR_NONE;
            mem_reg_write <= 1'b0;
            wb_write_en   <= 1'b0;
        end else begin
            mem_branch_op <= flush ? BR_NONE : ex_branch_op;
            mem_reg_write <= flush ? 1'b0 : ex_reg_write;
            wb_write_en   <= mem_reg_write; // Branch in EX/MEM still retires
        end
    end

    always_ff @(posedge clk) begin
        mem_alu_result    <= alu_result;
        mem_branch_target <= ex_pc + ex_imm;
        mem_rd            <= ex_rd;
        wb_rd             <= mem_rd;
        wb_data           <= mem_alu_result;
    end

endmodule

`default_nettype wire

/* rtl/instr_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_decode (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      flush,
    input  riscv_isa_pkg::instr_t     instr,
    input  riscv_isa_pkg::addr_t      fetch_pc,
    input  riscv_isa_pkg::xlen_t      rf_data_a,
    input  riscv_isa_pkg::xlen_t      rf_data_b,
    output riscv_isa_pkg::reg_idx_t   rs1_idx,
    output riscv_isa_pkg::reg_idx_t   rs2_idx,
    output riscv_isa_pkg::addr_t      ex_pc,
    output riscv_isa_pkg::reg_idx_t   ex_rs1,
    output riscv_isa_pkg::reg_idx_t   ex_rs2,
    output riscv_isa_pkg::reg_idx_t   ex_rd,
    output riscv_isa_pkg::xlen_t      ex_data_a,
    output riscv_isa_pkg::xlen_t      ex_data_b,
    output riscv_isa_pkg::xlen_t      ex_imm,
    output riscv_isa_pkg::alu_op_e    ex_alu_op,
    output logic                      ex_use_imm,
    output riscv_isa_pkg::branch_op_e ex_branch_op,
    output logic                      ex_reg_write
);
    import riscv_isa_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_sh;
    xlen_t      imm_b;
    xlen_t      imm_j;
    alu_op_e    dec_alu_op;
    branch_op_e dec_branch_op;
    xlen_t      dec_imm;
    logic       dec_use_imm;
    logic       dec_reg_write;

    // --------------------
    // Fields and immediates
    // --------------------
    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];

    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_sh = {27'b0, instr[24:20]};
    assign imm_b  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    function automatic alu_op_e alu_from_funct3(logic [2:0] f3, logic alt);
        case (f3)
            F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    // --------------------
    // Control decode
    // --------------------
    always_comb begin
        dec_alu_op    = ALU_ADD; // Bubble unless recognised
        dec_branch_op = BR_NONE;
        dec_imm       = imm_i;
        dec_use_imm   = 1'b0;
        dec_reg_write = 1'b0;
        case (opcode)
            OPC_OP: begin
                dec_reg_write = 1'b1;
                dec_alu_op    = alu_from_funct3(funct3, funct7 == FUNCT7_ALT);
            end
            OPC_OP_IMM: begin
                dec_reg_write = 1'b1;
                dec_use_imm   = 1'b1;
                // Only the right shift has an alternate form here
                dec_alu_op = alu_from_funct3(funct3,
                    funct3 == F3_SRL_SRA && funct7 == FUNCT7_ALT);
                if (funct3 == F3_SLL || funct3 == F3_SRL_SRA) begin
                    dec_imm = imm_sh;
                end
            end
            OPC_BRANCH: begin
                dec_imm = imm_b;
                case (funct3)
                    3'b000, 3'b001: dec_alu_op = ALU_SUB;  // BEQ, BNE
                    3'b100, 3'b101: dec_alu_op = ALU_SLT;  // BLT, BGE
                    3'b110, 3'b111: dec_alu_op = ALU_SLTU; // BLTU, BGEU
                    default: ;
                endcase
                if (funct3 != 3'b010 && funct3 != 3'b011) begin
                    dec_branch_op = branch_op_e'(funct3);
                end
            end
            OPC_JAL: begin
                dec_reg_write = 1'b1;
                dec_imm       = imm_j;
                dec_branch_op = BR_JUMP;
            end
            default: ;
        endcase
    end

    // --------------------
    // ID/EX register
    // --------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ex_alu_op    <= ALU_ADD;
            ex_use_imm   <= 1'b0;
            ex_branch_op <= BR_NONE;
            ex_reg_write <= 1'b0;
        end else if (flush) begin
            ex_alu_op    <= ALU_ADD;
            ex_use_imm   <= 1'b0;
            ex_branch_op <= BR_NONE;
            ex_reg_write <= 1'b0;
        end else begin
            ex_alu_op    <= dec_alu_op;
            ex_use_imm   <= dec_use_imm;
            ex_branch_op <= dec_branch_op;
            ex_reg_write <= dec_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc     <= fetch_pc;
        ex_rs1    <= rs1_idx;
        ex_rs2    <= rs2_idx;
        ex_rd     <= instr[11:7];
        ex_data_a <= rf_data_a;
        ex_data_b <= rf_data_b;
        ex_imm    <= dec_imm;
    end

endmodule

`default_nettype wire

/* rtl/pc_control.sv */
`timescale 1ns/100ps
`default_nettype none

module pc_control (
    input  logic                      clk,
    input  logic                      reset_n,
    input  riscv_isa_pkg::branch_op_e ex_branch_op,
    input  riscv_isa_pkg::xlen_t      ex_alu_result,
    input  riscv_isa_pkg::addr_t      ex_branch_target,
    output riscv_isa_pkg::addr_t      instr_addr,
    output riscv_isa_pkg::addr_t      fetch_pc,
    output logic                      flush
);
    import riscv_isa_pkg::*;
    import core_cfg_pkg::*;

    addr_t pc;
    logic  taken;

    // --------------------
    // Branch resolution
    // --------------------
    always_comb begin
        case (ex_branch_op)
            BR_BEQ:          taken = (ex_alu_result == '0); // SUB result
            BR_BNE:          taken = (ex_alu_result != '0);
            BR_BLT, BR_BLTU: taken = ex_alu_result[0];      // Set-less-than bit
            BR_BGE, BR_BGEU: taken = !ex_alu_result[0];
            BR_JUMP:         taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    // Squash the two younger instructions
    assign flush = taken;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc <= RESET_PC;
        end else if (taken) begin
            pc <= ex_branch_target;
        end else begin
            pc <= pc + INSTR_STEP;
        end
    end

    // Fetch is combinational so the decode address is the PC itself
    assign instr_addr = pc;
    assign fetch_pc   = pc;

    // Branch targets come from the decoded immediates
    pc_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        instr_addr[1:0] == 2'b00);

endmodule

`default_nettype wire

/* rtl/register_file.sv */
`timescale 1ns/100ps
`default_nettype none

module register_file (
    input  logic                    clk,
    input  logic                    reset_n,
    input  riscv_isa_pkg::reg_idx_t read_idx_a,
    input  riscv_isa_pkg::reg_idx_t read_idx_b,
    output riscv_isa_pkg::xlen_t    read_data_a,
    output riscv_isa_pkg::xlen_t    read_data_b,
    input  logic                    write_en,
    input  riscv_isa_pkg::reg_idx_t write_idx,
    input  riscv_isa_pkg::xlen_t    write_data,
    output riscv_isa_pkg::xlen_t    tap_data
);
    import riscv_isa_pkg::*;
    import core_cfg_pkg::*;

    xlen_t regs [NUM_REGS]; // Only reset ever writes x0

    function automatic xlen_t read_port(reg_idx_t idx);
        if (write_en && write_idx == idx && idx != '0) begin
            return write_data; // Write-through bypass
        end
        return regs[idx];
    endfunction

    always_comb begin
        read_data_a = read_port(read_idx_a);
        read_data_b = read_port(read_idx_b);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            regs[0] <= '0;
        end else if (write_en && write_idx != '0) begin
            regs[write_idx] <= write_data;
        end
    end

    assign tap_data = regs[TAP_REG]; // Debug tap

    x0_reads_zero: assert property (@(posedge clk) disable iff (!reset_n)
        (write_en && write_idx == '0) |=>
            (read_idx_a != '0 || read_data_a == '0) &&
            (read_idx_b != '0 || read_data_b == '0));

endmodule

`default_nettype wire

/* rtl/riscv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module riscv_core (
    input  logic                  clk,
    input  logic                  reset_n,
    output riscv_isa_pkg::addr_t  instr_addr,
    input  riscv_isa_pkg::instr_t instr_data,
    output riscv_isa_pkg::xlen_t  tap_data
);
    import riscv_isa_pkg::*;

    // Fetch and flush
    addr_t      fetch_pc;
    logic       flush;

    // Register file read side
    reg_idx_t   rs1_idx;
    reg_idx_t   rs2_idx;
    xlen_t      rf_data_a;
    xlen_t      rf_data_b;

    // ID/EX
    addr_t      ex_pc;
    reg_idx_t   ex_rs1;
    reg_idx_t   ex_rs2;
    reg_idx_t   ex_rd;
    xlen_t      ex_data_a;
    xlen_t      ex_data_b;
    xlen_t      ex_imm;
    alu_op_e    ex_alu_op;
    logic       ex_use_imm;
    branch_op_e ex_branch_op;
    logic       ex_reg_write;

    // EX/MEM and MEM/WB
    branch_op_e mem_branch_op;
    xlen_t      mem_alu_result;
    addr_t      mem_branch_target;
    logic       wb_write_en;
    reg_idx_t   wb_rd;
    xlen_t      wb_data;

    pc_control u_pc_control (
        .clk              (clk),
        .reset_n          (reset_n),
        .ex_branch_op     (mem_branch_op),
        .ex_alu_result    (mem_alu_result),
        .ex_branch_target (mem_branch_target),
        .instr_addr       (instr_addr),
        .fetch_pc         (fetch_pc),
        .flush            (flush)
    );

    register_file u_register_file (
        .clk         (clk),
        .reset_n     (reset_n),
        .read_idx_a  (rs1_idx),
        .read_idx_b  (rs2_idx),
        .read_data_a (rf_data_a),
        .read_data_b (rf_data_b),
        .write_en    (wb_write_en),
        .write_idx   (wb_rd),
        .write_data  (wb_data),
        .tap_data    (tap_data)
    );

    instr_decode u_instr_decode (
        .clk          (clk),
        .reset_n      (reset_n),
        .flush        (flush),
        .instr        (instr_data),
        .fetch_pc     (fetch_pc),
        .rf_data_a    (rf_data_a),
        .rf_data_b    (rf_data_b),
        .rs1_idx      (rs1_idx),
        .rs2_idx      (rs2_idx),
        .ex_pc        (ex_pc),
        .ex_rs1       (ex_rs1),
        .ex_rs2       (ex_rs2),
        .ex_rd        (ex_rd),
        .ex_data_a    (ex_data_a),
        .ex_data_b    (ex_data_b),
        .ex_imm       (ex_imm),
        .ex_alu_op    (ex_alu_op),
        .ex_use_imm   (ex_use_imm),
        .ex_branch_op (ex_branch_op),
        .ex_reg_write (ex_reg_write)
    );

    execute_stage u_execute_stage (
        .clk               (clk),
        .reset_n           (reset_n),
        .flush             (flush),
        .ex_pc             (ex_pc),
        .ex_rs1            (ex_rs1),
        .ex_rs2            (ex_rs2),
        .ex_rd             (ex_rd),
        .ex_data_a         (ex_data_a),
        .ex_data_b         (ex_data_b),
        .ex_imm            (ex_imm),
        .ex_alu_op         (ex_alu_op),
        .ex_use_imm        (ex_use_imm),
        .ex_branch_op      (ex_branch_op),
        .ex_reg_write      (ex_reg_write),
        .mem_branch_op     (mem_branch_op),
        .mem_alu_result    (mem_alu_result),
        .mem_branch_target (mem_branch_target),
        .wb_write_en       (wb_write_en),
        .wb_rd             (wb_rd),
        .wb_data           (wb_data)
    );

endmodule

`default_nettype wire

/* rtl/riscv_isa_pkg.sv */
`default_nettype none

package riscv_isa_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;

    // Major opcodes
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;

    localparam logic [6:0] FUNCT7_ALT = 7'b0100000; // SUB and SRA

    // ALU funct3 codes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // Conditional branches reuse their funct3
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_NONE = 3'b010,
        BR_JUMP = 3'b011,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_op_e;

endpackage

`default_nettype wire

/* sources.f */
+incdir+test
rtl/riscv_isa_pkg.sv
rtl/core_cfg_pkg.sv
rtl/alu.sv
rtl/pc_control.sv
rtl/register_file.sv
rtl/instr_decode.sv
rtl/execute_stage.sv
rtl/riscv_core.sv
test/tb_riscv_core.sv

/* test/tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// One row per program: 16 instruction words, run length, final a0,
// and one cycle at which instr_addr is checked against a fixed address.
// Unused words are NOPs and every program ends in a JAL x0, 0 self-loop

localparam int     NUM_PROGRAMS = 7;
localparam int     PROG_WORDS   = 16;
localparam instr_t NOP_WORD     = 32'h0000_0013; // addi x0, x0, 0

localparam instr_t PROGRAMS [NUM_PROGRAMS][PROG_WORDS] = '{
    // R-type chain, operands at distance 1, 2 and 3
    '{32'h00700093, 32'h00300113, 32'h002081B3, 32'h40218233,
      32'h003272B3, 32'h0032E333, 32'h004343B3, 32'h007120B3,
      32'h00139133, 32'h006131B3, 32'h00115233, 32'h404182B3,
      32'h4012D333, 32'h00234533, 32'h0000006F, 32'h00000013},
    // I-type with negative immediates, SLLI SRLI SRAI on negative values
    '{32'hF9C00093, 32'hFFF0C113, 32'hFF006193, 32'h0F00F213,
      32'hF9D0A293, 32'hFFF0B313, 32'h4020D393, 32'h01C0D113,
      32'h00419193, 32'h00238533, 32'h00350533, 32'h00450533,
      32'h40550533, 32'h40650533, 32'h0000006F, 32'h00000013},
    // BEQ and BNE, each taken then not taken
    '{32'hFFF00093, 32'h00100113, 32'h00000513, 32'h00108663,
      32'h10050513, 32'h20050513, 32'h00208463, 32'h00150513,
      32'h00209663, 32'h10050513, 32'h20050513, 32'h00211463,
      32'h00250513, 32'h01050513, 32'h0000006F, 32'h00000013},
    // BLT and BGE
    '{32'hFFF00093, 32'h00100113, 32'h00000513, 32'h0020C663,
      32'h10050513, 32'h20050513, 32'h0020D463, 32'h00150513,
      32'h00115663, 32'h10050513, 32'h20050513, 32'h00114463,
      32'h00250513, 32'h02050513, 32'h0000006F, 32'h00000013},
    // BLTU and BGEU, operands differ in signed and unsigned order
    '{32'hFFF00093, 32'h00100113, 32'h00000513, 32'h00116663,
      32'h10050513, 32'h20050513, 32'h00117463, 32'h00150513,
      32'h0020F663, 32'h10050513, 32'h20050513, 32'h0020E463,
      32'h00250513, 32'h03050513, 32'h0000006F, 32'h00000013},
    // JAL a0, +16 from address 4
    '{32'h07700513, 32'h0100056F, 32'h10050513, 32'h20050513,
      32'h7FF00513, 32'h0000006F, 32'h00000013, 32'h00000013,
      32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013,
      32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013},
    // Writes to x0, read back at distance 1, 2 and 3
    '{32'h00900093, 32'h06408013, 32'h00100533, 32'h00700013,
      32'h00000013, 32'h00050533, 32'h00350013, 32'h00000013,
      32'h00000013, 32'h00A00533, 32'h0000006F, 32'h00000013,
      32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013}
};

localparam int    RUN_CYCLES  [NUM_PROGRAMS] = '{24, 24, 24, 24, 24, 16, 20};
localparam xlen_t EXPECT_A0   [NUM_PROGRAMS] = '{32'hFFFF_FFE3, 32'hFFFF_FF84,
    32'h0000_0013, 32'h0000_0023, 32'h0000_0033, 32'h0000_0008, 32'h0000_0009};
localparam int    ADDR_CYCLE  [NUM_PROGRAMS] = '{17, 8, 6, 11, 6, 4, 13};
localparam addr_t ADDR_EXPECT [NUM_PROGRAMS] = '{32'h38, 32'h20, 32'h18, 32'h2C,
    32'h18, 32'h14, 32'h28};

`endif

/* test/tb_riscv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_riscv_core;
    import riscv_isa_pkg::*;
    import core_cfg_pkg::*;

    `include "tb_programs.svh"

    localparam int RESET_CYCLES   = 4;
    localparam int IMEM_WORDS     = 32;
    localparam int TIMEOUT_MARGIN = 50;

    logic   clk;
    logic   reset_n;
    addr_t  instr_addr;
    instr_t instr_data;
    xlen_t  tap_data;

    instr_t imem [IMEM_WORDS];
    int     word_errors = 0;
    int     addr_errors = 0;
    int     cycle_count = 0;

    riscv_core dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .tap_data   (tap_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Instruction memory, answers in the same cycle
    always_comb begin
        if (instr_addr < addr_t'(IMEM_WORDS * 4)) begin
            instr_data = imem[instr_addr[6:2]];
        end else begin
            instr_data = NOP_WORD; // Past the end of memory
        end
    end

    // --------------------
    // Checks
    // --------------------
    task automatic check_word(input string name, input xlen_t actual, input xlen_t expected);
        if (actual !== expected) begin
            word_errors++;
            $display("CHECK FAILED at %0t: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic check_addr(input string name, input addr_t actual, input addr_t expected);
        if (actual !== expected) begin
            addr_errors++;
            $display("CHECK FAILED at %0t: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic print_summary();
        $display("Errors: %0d on tap_data, %0d on instr_addr", word_errors, addr_errors);
    endtask

    // --------------------
    // Program runs
    // --------------------
    task automatic load_program(input int prog);
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = (i < PROG_WORDS) ? PROGRAMS[prog][i] : NOP_WORD;
        end
    endtask

    task automatic run_program(input int prog);
        string tag;
        tag = $sformatf("program %0d", prog);
        @(negedge clk);
        reset_n = 1'b0;
        load_program(prog);
        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;
        check_addr({tag, " instr_addr"}, instr_addr, RESET_PC); // Cycle 0
        for (int c = 1; c <= RUN_CYCLES[prog]; c++) begin
            @(negedge clk);
            // No redirect can land before cycle 3
            if (c <= 2) begin
                check_addr({tag, " instr_addr"}, instr_addr, addr_t'(RESET_PC + INSTR_STEP * c));
            end
            if (c == ADDR_CYCLE[prog]) begin
                check_addr({tag, " instr_addr"}, instr_addr, ADDR_EXPECT[prog]);
            end
        end
        check_word({tag, " tap_data"}, tap_data, EXPECT_A0[prog]);
    endtask

    initial begin
        reset_n = 1'b0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = NOP_WORD;
        end
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            run_program(p);
        end
        print_summary();
        if (word_errors == 0 && addr_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        int limit;
        limit = TIMEOUT_MARGIN;
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            limit += RUN_CYCLES[p] + RESET_CYCLES + 2;
        end
        while (cycle_count < limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the programs did not finish within %0d cycles", limit);
        print_summary();
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
